// ==== common/mul_pkg.sv ====
package mul_pkg;

	localparam int xlen = 64;
	localparam int tag_w = 4;

	typedef enum logic [2:0] {
		mul_lo    = 3'd0,
		mul_hi_ss = 3'd1,
		mul_hi_su = 3'd2,
		mul_hi_uu = 3'd3,
		mul_w     = 3'd4
	} mul_op_e;

	typedef struct packed {
		mul_op_e          op;
		logic [tag_w-1:0] tag;
		logic [xlen-1:0]  a;
		logic [xlen-1:0]  b;
	} mul_req_t;

	typedef struct packed {
		mul_op_e          op;
		logic [tag_w-1:0] tag;
		logic [xlen-1:0]  mag_a;
		logic [xlen-1:0]  mag_b;
		logic             neg; // product sign
	} mul_job_t;

	typedef struct packed {
		mul_op_e           op;
		logic [tag_w-1:0]  tag;
		logic              neg;
		logic [2*xlen-1:0] prod; // unsigned magnitude product
	} mul_prod_t;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [xlen-1:0]  result;
	} mul_resp_t;

	function automatic logic op_is_word(input mul_op_e op);
		return op == mul_w;
	endfunction

	// low result bits do not depend on operand signedness
	function automatic logic a_signed(input mul_op_e op);
		return op inside {mul_lo, mul_hi_ss, mul_hi_su, mul_w};
	endfunction

	function automatic logic b_signed(input mul_op_e op);
		return op inside {mul_lo, mul_hi_ss, mul_w};
	endfunction

endpackage

// ==== mul_unit/mul_operand_prep.sv ====
`timescale 1ns/1ps

module mul_operand_prep #(
	parameter int IN_CREDITS = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               req_valid,
	input  mul_pkg::mul_req_t  req,
	output logic               in_credit,
	output logic               job_valid,
	output mul_pkg::mul_job_t  job,
	input  logic               core_idle
);
	import mul_pkg::*;

	localparam int ptr_w = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
	localparam int cnt_w = $clog2(IN_CREDITS + 1);

	mul_req_t         q_mem [IN_CREDITS];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;
	mul_req_t         head;
	logic [xlen-1:0]  opa;
	logic [xlen-1:0]  opb;
	logic             sa;
	logic             sb;

	assign push = req_valid && !flush;
	assign job_valid = count != '0;
	assign pop = job_valid && core_idle && !flush;
	assign in_credit = pop; // credit back to the issuer as a slot frees

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			q_mem[wr_ptr] <= req;
	end

	always_comb begin
		head = q_mem[rd_ptr];
		if (op_is_word(head.op)) begin
			sa = a_signed(head.op) && head.a[31];
			sb = b_signed(head.op) && head.b[31];
			opa = {{32{sa}}, head.a[31:0]}; // upper bits ignored
			opb = {{32{sb}}, head.b[31:0]};
		end else begin
			sa = a_signed(head.op) && head.a[xlen-1];
			sb = b_signed(head.op) && head.b[xlen-1];
			opa = head.a;
			opb = head.b;
		end
		job.op = head.op;
		job.tag = head.tag;
		job.mag_a = sa ? ~opa + 1'b1 : opa;
		job.mag_b = sb ? ~opb + 1'b1 : opb;
		job.neg = sa ^ sb;
	end

	// issuer must hold a credit for every push
	a_no_push_full: assert property (@(posedge clk) disable iff (reset || flush)
		req_valid |-> count < cnt_w'(IN_CREDITS))
		else $error("operand queue overrun, issuer credit violation");

endmodule

// ==== mul_unit/mul_shift_add.sv ====
`timescale 1ns/1ps

module mul_shift_add (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               job_valid,
	input  mul_pkg::mul_job_t  job,
	output logic               core_idle,
	output logic               prod_valid,
	output mul_pkg::mul_prod_t prod,
	input  logic               fmt_ready
);
	import mul_pkg::*;

	localparam int cnt_w = $clog2(xlen);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} state_e;

	state_e            state;
	logic [2*xlen-1:0] acc;
	logic [2*xlen-1:0] mcand;
	logic [xlen-1:0]   mplier;
	logic [cnt_w-1:0]  bit_cnt;
	logic [cnt_w-1:0]  last_bit;
	mul_op_e           op_q;
	logic [tag_w-1:0]  tag_q;
	logic              neg_q;
	logic              take;

	assign core_idle = state == st_idle;
	assign take = job_valid && core_idle;
	assign last_bit = op_is_word(op_q) ? cnt_w'(31) : cnt_w'(xlen - 1);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (job_valid)
						state <= st_run;
				end
				st_run: begin
					if (bit_cnt == last_bit)
						state <= st_done;
				end
				st_done: begin
					if (fmt_ready)
						state <= st_idle; // formatter took it
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			acc <= '0;
			mcand <= {{xlen{1'b0}}, job.mag_a};
			mplier <= job.mag_b;
			bit_cnt <= '0;
			op_q <= job.op;
			tag_q <= job.tag;
			neg_q <= job.neg;
		end else if (state == st_run) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	assign prod_valid = state == st_done;
	assign prod.op = op_q;
	assign prod.tag = tag_q;
	assign prod.neg = neg_q;
	assign prod.prod = acc;

	// a waiting job stays put until the core is idle to take it
	a_job_wait: assert property (@(posedge clk) disable iff (reset || flush)
		(job_valid && !core_idle) |=> (job_valid && $stable(job)))
		else $error("job changed before the core took it");

	// word jobs must carry a 32-bit multiplier
	a_mplier_used: assert property (@(posedge clk) disable iff (reset || flush)
		prod_valid |-> mplier == '0)
		else $error("multiplier bits left over at the end of the run");

endmodule

// ==== mul_unit/mul_result_fmt.sv ====
`timescale 1ns/1ps

module mul_result_fmt #(
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               prod_valid,
	input  mul_pkg::mul_prod_t prod,
	output logic               fmt_ready,
	output logic               resp_valid,
	output mul_pkg::mul_resp_t resp,
	input  logic               out_credit
);
	import mul_pkg::*;

	localparam int ptr_w = (OUT_CREDITS > 1) ? $clog2(OUT_CREDITS) : 1;
	localparam int cnt_w = $clog2(OUT_CREDITS + 1);

	mul_resp_t         rbuf [OUT_CREDITS];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;
	logic [cnt_w-1:0]  cred;
	logic [2*xlen-1:0] full;
	logic [xlen-1:0]   res;
	logic              wr_en;
	logic              send;

	always_comb begin
		full = prod.neg ? ~prod.prod + 1'b1 : prod.prod; // whole 128-bit negate
		case (prod.op)
			mul_lo:  res = full[xlen-1:0];
			mul_w:   res = {{32{full[31]}}, full[31:0]};
			default: res = full[2*xlen-1:xlen];
		endcase
	end

	assign fmt_ready = count != cnt_w'(OUT_CREDITS);
	assign wr_en = prod_valid && fmt_ready && !flush;
	assign send = (count != '0) && (cred != '0) && !flush;
	assign resp_valid = send;
	assign resp = rbuf[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == ptr_w'(OUT_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (send)
				rd_ptr <= (rd_ptr == ptr_w'(OUT_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cnt_w'(wr_en) - cnt_w'(send);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			rbuf[wr_ptr].tag <= prod.tag;
			rbuf[wr_ptr].result <= res;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			cred <= cnt_w'(OUT_CREDITS); // flush leaves this alone
		else
			cred <= cred - cnt_w'(send) + cnt_w'(out_credit);
	end

	a_cred_bound: assert property (@(posedge clk) disable iff (reset)
		cred <= cnt_w'(OUT_CREDITS))
		else $error("consumer returned more credits than granted");

	// core must hold its product while the buffer is full
	a_prod_hold: assert property (@(posedge clk) disable iff (reset || flush)
		(prod_valid && !fmt_ready) |=> (prod_valid && $stable(prod)))
		else $error("product dropped under back-pressure");

endmodule

// ==== hdl/mul_top.sv ====
`timescale 1ns/1ps

module mul_top #(
	parameter int IN_CREDITS  = 2,
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               req_valid,
	input  mul_pkg::mul_req_t  req,
	output logic               in_credit,
	output logic               resp_valid,
	output mul_pkg::mul_resp_t resp,
	input  logic               out_credit
);
	import mul_pkg::*;

	logic      job_valid;
	mul_job_t  job;
	logic      core_idle;
	logic      prod_valid;
	mul_prod_t prod;
	logic      fmt_ready;

	mul_operand_prep #(
		.IN_CREDITS(IN_CREDITS)
	) mul_operand_prep_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.req_valid(req_valid),
		.req(req),
		.in_credit(in_credit),
		.job_valid(job_valid),
		.job(job),
		.core_idle(core_idle)
	);

	mul_shift_add mul_shift_add_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.job_valid(job_valid),
		.job(job),
		.core_idle(core_idle),
		.prod_valid(prod_valid),
		.prod(prod),
		.fmt_ready(fmt_ready)
	);

	mul_result_fmt #(
		.OUT_CREDITS(OUT_CREDITS)
	) mul_result_fmt_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.prod_valid(prod_valid),
		.prod(prod),
		.fmt_ready(fmt_ready),
		.resp_valid(resp_valid),
		.resp(resp),
		.out_credit(out_credit)
	);

endmodule

// ==== tb/mul_checker.sv ====
`timescale 1ns/1ps

module mul_checker #(
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               req_valid,
	input  mul_pkg::mul_req_t  req,
	input  logic               in_credit,
	input  logic               resp_valid,
	input  mul_pkg::mul_resp_t resp,
	input  logic               out_credit,
	output int                 value_errors,
	output int                 protocol_errors,
	output int                 pending
);
	import mul_pkg::*;

	mul_resp_t expect_q [$];
	int        value_cnt = 0;
	int        protocol_cnt = 0;
	int        pend_cnt = 0;
	int        queued = 0; // accepted and still waiting for in_credit
	int        cred = OUT_CREDITS;

	assign value_errors = value_cnt;
	assign protocol_errors = protocol_cnt;
	assign pending = pend_cnt;

	// full 128-bit product of the extended operands before half select
	function automatic logic [63:0] mul_ref(input mul_op_e op, input logic [63:0] a,
		input logic [63:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		case (op)
			mul_w: begin
				ea = {{96{a[31]}}, a[31:0]};
				eb = {{96{b[31]}}, b[31:0]};
			end
			mul_lo, mul_hi_ss: begin
				ea = {{64{a[63]}}, a};
				eb = {{64{b[63]}}, b};
			end
			mul_hi_su: begin
				ea = {{64{a[63]}}, a};
				eb = {64'h0, b};
			end
			default: begin
				ea = {64'h0, a};
				eb = {64'h0, b};
			end
		endcase
		p = ea * eb;
		case (op)
			mul_lo:  return p[63:0];
			mul_w:   return {{32{p[31]}}, p[31:0]};
			default: return p[127:64];
		endcase
	endfunction

	// inputs and outputs are settled here for the coming edge
	always @(negedge clk) begin
		mul_resp_t exp_r;
		mul_resp_t new_r;
		if (reset) begin
			expect_q.delete();
			queued = 0;
			cred = OUT_CREDITS;
		end else begin
			if (resp_valid) begin
				if (cred == 0) begin
					$display("response sent while the consumer had no free slot at %0t", $time);
					protocol_cnt++;
				end else begin
					cred--;
				end
				if (expect_q.size() == 0) begin
					$display("response with no request outstanding at %0t", $time);
					protocol_cnt++;
				end else begin
					exp_r = expect_q.pop_front();
					if (resp != exp_r) begin
						$display("ERROR %0t: tag %0h result %h, expected tag %0h result %h",
							$time, resp.tag, resp.result, exp_r.tag, exp_r.result);
						value_cnt++;
					end
				end
			end
			if (out_credit)
				cred++;
			if (in_credit) begin
				if (queued == 0) begin
					$display("in_credit pulsed with no request in the queue at %0t", $time);
					protocol_cnt++;
				end else begin
					queued--;
				end
			end
			if (flush) begin
				expect_q.delete(); // work in flight is dropped
				queued = 0;
			end else if (req_valid) begin
				new_r.tag = req.tag;
				new_r.result = mul_ref(req.op, req.a, req.b);
				expect_q.push_back(new_r);
				queued++;
			end
		end
		pend_cnt = expect_q.size();
	end

endmodule

// ==== tb/mul_tb.sv ====
`timescale 1ns/1ps

module mul_tb;
	import mul_pkg::*;

	localparam int IN_CREDITS = 2;
	localparam int OUT_CREDITS = 2;
	localparam int wait_limit = 5000;

	logic             clk;
	logic             reset;
	logic             flush;
	logic             req_valid;
	mul_req_t         req;
	logic             in_credit;
	logic             resp_valid;
	mul_resp_t        resp;
	logic             out_credit;
	int               value_errors;
	int               protocol_errors;
	int               pending;
	int               timeout_errors = 0;
	int               credits = 0;
	logic             hold_credits = 1'b0;
	logic             aborted = 1'b0;
	logic [31:0]      rng_state = 32'hdea57115;
	logic [31:0]      pace_state = 32'h7115dea5; // second stream for consumer pacing
	logic [tag_w-1:0] next_tag = '0;

	mul_top #(
		.IN_CREDITS(IN_CREDITS),
		.OUT_CREDITS(OUT_CREDITS)
	) mul_top_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.req_valid(req_valid),
		.req(req),
		.in_credit(in_credit),
		.resp_valid(resp_valid),
		.resp(resp),
		.out_credit(out_credit)
	);

	mul_checker #(
		.OUT_CREDITS(OUT_CREDITS)
	) mul_checker_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.req_valid(req_valid),
		.req(req),
		.in_credit(in_credit),
		.resp_valid(resp_valid),
		.resp(resp),
		.out_credit(out_credit),
		.value_errors(value_errors),
		.protocol_errors(protocol_errors),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = lcg_next(rng_state);
		return rng_state;
	endfunction

	function automatic logic [63:0] corner(input int idx);
		case (idx)
			0: return 64'h0;
			1: return 64'h1;
			2: return 64'hffff_ffff_ffff_ffff;
			3: return 64'h8000_0000_0000_0000;
			4: return 64'h0000_0000_ffff_ffff;
			5: return 64'h0000_0000_8000_0000;
			6: return 64'h0000_0001_0000_0000;
			7: return 64'hffff_ffff_7fff_ffff;
			default: return 64'hdead_beef_8000_0001; // junk above bit 31
		endcase
	endfunction

	function automatic logic [63:0] pick_operand();
		logic [31:0] r;
		logic [31:0] hi;
		r = rand32();
		if (r[31:30] == 2'b00)
			return corner(int'(r[15:0] % 16'd9));
		hi = rand32();
		return {hi, rand32()};
	endfunction

	function automatic mul_op_e pick_op();
		logic [31:0] r;
		r = rand32();
		return mul_op_e'(3'(r[31:16] % 16'd5));
	endfunction

	// issuer credit count settled before the next edge
	always @(negedge clk) begin
		if (reset || flush) begin
			credits = IN_CREDITS;
		end else begin
			if (in_credit)
				credits++;
			if (req_valid)
				credits--;
		end
	end

	// consumer frees its slots at a random pace unless held
	initial begin
		int   held;
		logic hold_now;
		held = 0;
		hold_now = 1'b0;
		out_credit = 1'b0;
		forever begin
			@(negedge clk);
			if (resp_valid)
				held++;
			if (out_credit)
				held--;
			hold_now = hold_credits;
			@(posedge clk);
			#1;
			pace_state = lcg_next(pace_state);
			out_credit = (held > 0) && !hold_now && (pace_state[31:30] != 2'b00);
		end
	end

	task automatic pause(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic issue(input mul_op_e op, input logic [63:0] a, input logic [63:0] b);
		int waited;
		waited = 0;
		while (credits == 0 && !aborted) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit) begin
				$display("timed out waiting for an issuer credit at %0t", $time);
				timeout_errors++;
				aborted = 1'b1;
			end
		end
		if (!aborted) begin
			req_valid = 1'b1;
			req.op = op;
			req.tag = next_tag;
			req.a = a;
			req.b = b;
			next_tag++;
			@(posedge clk);
			#1;
			req_valid = 1'b0;
		end
	endtask

	task automatic issue_random();
		mul_op_e     op;
		logic [63:0] a;
		logic [63:0] b;
		op = pick_op();
		a = pick_operand();
		b = pick_operand();
		issue(op, a, b);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending != 0 && !aborted) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit) begin
				$display("timed out with %0d responses still missing at %0t", pending, $time);
				timeout_errors++;
				aborted = 1'b1;
			end
		end
	endtask

	task automatic do_flush();
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	initial begin
		int total;
		reset = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		pause(20); // quiet after reset
		for (int i = 0; i < 400; i++)
			issue_random();
		wait_drain();
		for (int k = 0; k < 5; k++)
			for (int ia = 0; ia < 9; ia++)
				for (int ib = 0; ib < 9; ib++)
					issue(mul_op_e'(3'(k)), corner(ia), corner(ib));
		wait_drain();
		for (int r = 0; r < 3; r++) begin
			hold_credits = 1'b1;
			for (int i = 0; i < 5; i++)
				issue_random(); // fills queue, core and buffer
			pause(300);
			hold_credits = 1'b0;
			wait_drain();
		end
		for (int r = 0; r < 3; r++) begin
			hold_credits = (r == 1);
			for (int i = 0; i < 4; i++)
				issue_random();
			pause(10 + int'(rand32() % 32'd110));
			do_flush();
			hold_credits = 1'b0;
			for (int i = 0; i < 10; i++)
				issue_random();
			wait_drain();
		end
		pause(10);
		total = value_errors + protocol_errors + timeout_errors;
		$display("errors: %0d value, %0d protocol, %0d timeout",
			value_errors, protocol_errors, timeout_errors);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== list.f ====
common/mul_pkg.sv
mul_unit/mul_operand_prep.sv
mul_unit/mul_shift_add.sv
mul_unit/mul_result_fmt.sv
hdl/mul_top.sv
tb/mul_checker.sv
tb/mul_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module mul_tb -Mdir obj_dir -f list.f

run: compile
	./obj_dir/Vmul_tb | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported a failure, see sim.log"; \
		exit 1; \
	fi
	@grep -q "Regression passed" sim.log || \
		(echo "simulation ended without a result line, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
